// ==== tc_fmt_pkg.sv ====
package tc_fmt_pkg;

    // operand and result formats
    localparam int EXP_W      = 5;
    localparam int IN_FRAC_W  = 8;
    localparam int OUT_FRAC_W = 4;

    localparam logic [EXP_W-1:0] EXP_MAX = {EXP_W{1'b1}};  // inf and nan exponent

    // hidden bit + fraction + two guard bits
    localparam int SIG_W   = IN_FRAC_W + 3;
    // hidden bit position inside the aligned sum, sticky sits at bit 0
    localparam int HID_POS = SIG_W;
    localparam int ALIGN_W = SIG_W + 3;  // two sign extension bits and sticky on top
    localparam int LZD_W   = 4;          // leading one index over 16 bits

    typedef struct packed {
        logic                 sign;
        logic [EXP_W-1:0]     exp;
        logic [IN_FRAC_W-1:0] frac;
    } in_operand_t;

    typedef struct packed {
        logic                  sign;
        logic [EXP_W-1:0]      exp;
        logic [OUT_FRAC_W-1:0] frac;
    } out_result_t;

    // handoff from normalize to round
    typedef struct packed {
        logic                  sign;
        logic [EXP_W-1:0]      exp;
        logic [OUT_FRAC_W-1:0] mant;    // truncated output fraction
        logic                  guard;
        logic                  round;
        logic                  sticky;
    } pre_round_t;

endpackage

// ==== tc_flag_pkg.sv ====
package tc_flag_pkg;

    // fflags bit positions
    localparam int IDX_NV = 4;
    localparam int IDX_OF = 3;
    localparam int IDX_UF = 2;
    localparam int IDX_DZ = 1;
    localparam int IDX_NX = 0;

    // special operand combinations found in stage 1
    typedef enum logic [1:0] {
        SP_NONE,     // finite operands
        SP_NAN,      // nan input propagates as quiet nan
        SP_INVALID,  // inf minus inf
        SP_INF       // one or two infinities of the same sign
    } sp_class_e;

    typedef struct packed {
        sp_class_e cls;
        logic      inf_sign;  // sign of the infinite operand
        logic      sel_far;   // exponent gap of 2 or more
    } special_t;

    typedef logic [4:0] fflags_t;

endpackage

// ==== fp_align_add.sv ====
`timescale 1ns/1ns

module fp_align_add
    import tc_fmt_pkg::*, tc_flag_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en_i,
    input  in_operand_t        a_i,
    input  in_operand_t        b_i,
    output logic [ALIGN_W-1:0] sum_o,
    output logic [EXP_W-1:0]   exp_large_o,
    output in_operand_t        a_o,
    output in_operand_t        b_o,
    output logic               bypass_a0_o,
    output logic               bypass_b0_o,
    output special_t           spec_o
);

    function automatic logic is_zero(input in_operand_t x);
        return (x.exp == '0) && (x.frac == '0);
    endfunction

    function automatic logic is_nan(input in_operand_t x);
        return (&x.exp) && (|x.frac);
    endfunction

    function automatic logic is_inf(input in_operand_t x);
        return (&x.exp) && (x.frac == '0);
    endfunction

    // subnormals sit at exponent 1 with a zero hidden bit
    function automatic logic [EXP_W-1:0] eff_exp(input in_operand_t x);
        return (|x.exp) ? x.exp : EXP_W'(1);
    endfunction

    function automatic logic [SIG_W-1:0] sig_of(input in_operand_t x);
        return {|x.exp, x.frac, 2'b00};
    endfunction

    logic               a_zero, b_zero, a_nan, b_nan, a_inf, b_inf;
    logic [EXP_W-1:0]   a_exp, b_exp;
    logic               a_ge_b;
    in_operand_t        op_large, op_small;
    logic [EXP_W-1:0]   exp_large, shift;
    logic [SIG_W+2**EXP_W-1:0] small_ext;
    logic               sticky;
    logic [ALIGN_W-1:0] large_mag, small_mag;
    logic [ALIGN_W-1:0] large_tc, small_tc, sum;
    special_t           spec_d;

    assign a_zero = is_zero(a_i);
    assign b_zero = is_zero(b_i);
    assign a_nan  = is_nan(a_i);
    assign b_nan  = is_nan(b_i);
    assign a_inf  = is_inf(a_i);
    assign b_inf  = is_inf(b_i);

    assign a_exp  = eff_exp(a_i);
    assign b_exp  = eff_exp(b_i);
    assign a_ge_b = (a_exp >= b_exp);

    assign op_large  = a_ge_b ? a_i : b_i;
    assign op_small  = a_ge_b ? b_i : a_i;
    assign exp_large = a_ge_b ? a_exp : b_exp;
    assign shift     = a_ge_b ? (a_exp - b_exp) : (b_exp - a_exp);

    // low part is wide enough that no shift drops a bit
    assign small_ext = {sig_of(op_small), {(2**EXP_W){1'b0}}} >> shift;
    assign sticky    = |small_ext[2**EXP_W-1:0];

    assign large_mag = {2'b00, sig_of(op_large), 1'b0};
    assign small_mag = {2'b00, small_ext[SIG_W+2**EXP_W-1 -: SIG_W], sticky};

    assign large_tc = op_large.sign ? (~large_mag + 1'b1) : large_mag;
    assign small_tc = op_small.sign ? (~small_mag + 1'b1) : small_mag;
    assign sum      = large_tc + small_tc;  // cannot overflow with 2 extension bits

    always_comb begin
        spec_d.cls = SP_NONE;
        if (a_nan || b_nan) begin
            spec_d.cls = SP_NAN;
        end else if (a_inf && b_inf && (a_i.sign != b_i.sign)) begin
            spec_d.cls = SP_INVALID;
        end else if (a_inf || b_inf) begin
            spec_d.cls = SP_INF;
        end
        spec_d.inf_sign = a_inf ? a_i.sign : b_i.sign;
        spec_d.sel_far  = (shift >= EXP_W'(2));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_o       <= '0;
            exp_large_o <= '0;
            a_o         <= '0;
            b_o         <= '0;
            bypass_a0_o <= 1'b0;
            bypass_b0_o <= 1'b0;
            spec_o      <= '0;
        end else if (en_i) begin
            sum_o       <= sum;
            exp_large_o <= exp_large;
            a_o         <= a_i;
            b_o         <= b_i;
            bypass_a0_o <= a_zero & ~b_zero;  // a is zero so b passes
            bypass_b0_o <= b_zero & ~a_zero;
            spec_o      <= spec_d;
        end
    end

    // a nan operand must never be carried down as an infinity
    nan_not_inf_a: assert property (@(posedge clk) disable iff (!rst_n)
        (is_nan(a_o) || is_nan(b_o)) |-> (spec_o.cls != SP_INF))
        else $error("inf class registered with a nan operand");

endmodule

// ==== fp_normalize.sv ====
`timescale 1ns/1ns

module fp_normalize
    import tc_fmt_pkg::*, tc_flag_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en_i,
    input  logic [ALIGN_W-1:0] sum_i,
    input  logic [EXP_W-1:0]   exp_large_i,
    input  in_operand_t        a_i,
    input  in_operand_t        b_i,
    input  logic               bypass_a0_i,
    input  logic               bypass_b0_i,
    input  special_t           spec_i,
    output pre_round_t         sig_o,
    output special_t           spec_o
);

    // drop an input fraction straight to output width plus grs
    function automatic pre_round_t pack_bypass(input in_operand_t x);
        pre_round_t p;
        p.sign   = x.sign;
        p.exp    = x.exp;
        p.mant   = x.frac[IN_FRAC_W-1 -: OUT_FRAC_W];
        p.guard  = x.frac[IN_FRAC_W-1-OUT_FRAC_W];
        p.round  = x.frac[IN_FRAC_W-2-OUT_FRAC_W];
        p.sticky = |x.frac[IN_FRAC_W-3-OUT_FRAC_W:0];
        return p;
    endfunction

    logic [ALIGN_W-1:0]    mag;
    logic [2**LZD_W-1:0]   lzd_in;
    logic [7:0]            part1;
    logic [3:0]            part2;
    logic [1:0]            part3;
    logic [LZD_W-1:0]      lead;     // index of the leading one
    logic [EXP_W:0]        exp_sum;
    logic [ALIGN_W-1:0]    norm;
    logic [EXP_W-1:0]      norm_exp;
    logic                  lost;
    pre_round_t            norm_sig;
    pre_round_t            sig_d;

    assign mag    = sum_i[ALIGN_W-1] ? (~sum_i + 1'b1) : sum_i;
    assign lzd_in = {{(2**LZD_W-ALIGN_W){1'b0}}, mag};

    // binary search for the leading one, halving the window each level
    assign lead[3] = |lzd_in[15:8];
    assign part1   = lead[3] ? lzd_in[15:8] : lzd_in[7:0];
    assign lead[2] = |part1[7:4];
    assign part2   = lead[2] ? part1[7:4] : part1[3:0];
    assign lead[1] = |part2[3:2];
    assign part3   = lead[1] ? part2[3:2] : part2[1:0];
    assign lead[0] = part3[1];

    assign exp_sum = {1'b0, exp_large_i} + (EXP_W+1)'(lead);

    always_comb begin
        lost     = 1'b0;
        norm_exp = exp_sum[EXP_W-1:0] - EXP_W'(HID_POS);
        if (lead > LZD_W'(HID_POS)) begin
            // add carried past the hidden bit
            norm = mag >> 1;
            lost = mag[0];
        end else if (exp_sum > (EXP_W+1)'(HID_POS)) begin
            norm = mag << (LZD_W'(HID_POS) - lead);
        end else begin
            // result is subnormal so scale to emin only
            norm     = mag << (exp_large_i - 1'b1);
            norm_exp = '0;
        end
    end

    assign norm_sig.sign   = sum_i[ALIGN_W-1];
    assign norm_sig.exp    = norm_exp;
    assign norm_sig.mant   = norm[HID_POS-1 -: OUT_FRAC_W];
    assign norm_sig.guard  = norm[HID_POS-1-OUT_FRAC_W];
    assign norm_sig.round  = norm[HID_POS-2-OUT_FRAC_W];
    assign norm_sig.sticky = (|norm[HID_POS-3-OUT_FRAC_W:0]) | lost;

    always_comb begin
        if (mag == '0) begin
            sig_d = '0;                  // exact cancellation gives +0
        end else if (bypass_a0_i) begin
            sig_d = pack_bypass(b_i);
        end else if (bypass_b0_i) begin
            sig_d = pack_bypass(a_i);
        end else begin
            sig_d = norm_sig;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sig_o  <= '0;
            spec_o <= '0;
        end else if (en_i) begin
            sig_o  <= sig_d;
            spec_o <= spec_i;            // class travels with its data
        end
    end

endmodule

// ==== fp_round_pack.sv ====
`timescale 1ns/1ns

module fp_round_pack
    import tc_fmt_pkg::*, tc_flag_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en_i,
    input  pre_round_t  sig_i,
    input  special_t    spec_i,
    output out_result_t result_o,
    output fflags_t     fflags_o,
    output logic        far_uf_o,
    output logic        near_of_o
);

    logic                use_nan, use_inf, special;
    logic                any_rb, inc, carry;
    logic [OUT_FRAC_W:0] mant_rnd;
    logic [EXP_W:0]      exp_rnd;
    logic                of, uf;
    out_result_t         res_d;
    fflags_t             flags_d;

    assign use_nan = (spec_i.cls == SP_NAN) || (spec_i.cls == SP_INVALID);
    assign use_inf = (spec_i.cls == SP_INF);
    assign special = use_nan || use_inf;

    // round to nearest, ties to even
    assign any_rb   = sig_i.guard | sig_i.round | sig_i.sticky;
    assign inc      = sig_i.guard & (sig_i.round | sig_i.sticky | sig_i.mant[0]);
    assign mant_rnd = {1'b0, sig_i.mant} + (OUT_FRAC_W+1)'(inc);
    assign carry    = mant_rnd[OUT_FRAC_W];  // fraction wrapped to zero
    assign exp_rnd  = {1'b0, sig_i.exp} + (EXP_W+1)'(carry);

    // catches both a rounding carry and an add carry into EXP_MAX
    assign of = !special && (exp_rnd >= {1'b0, EXP_MAX});
    assign uf = !special && (sig_i.exp == '0) && (sig_i.mant == '0) && any_rb;

    always_comb begin
        res_d.sign = sig_i.sign;
        res_d.exp  = exp_rnd[EXP_W-1:0];
        res_d.frac = mant_rnd[OUT_FRAC_W-1:0];
        if (use_nan) begin
            res_d.sign = 1'b0;
            res_d.exp  = EXP_MAX;
            res_d.frac = {1'b1, {(OUT_FRAC_W-1){1'b0}}};  // canonical quiet nan
        end else if (use_inf) begin
            res_d.sign = spec_i.inf_sign;
            res_d.exp  = EXP_MAX;
            res_d.frac = '0;
        end else if (of) begin
            // signed inf keeps the sum sign
            res_d.exp  = EXP_MAX;
            res_d.frac = '0;
        end
    end

    always_comb begin
        flags_d         = '0;
        flags_d[IDX_NV] = (spec_i.cls == SP_INVALID);  // nan inputs stay quiet
        flags_d[IDX_OF] = of;
        flags_d[IDX_UF] = uf;
        flags_d[IDX_DZ] = 1'b0;
        flags_d[IDX_NX] = (!special && any_rb) || of || uf;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_o  <= '0;
            fflags_o  <= '0;
            far_uf_o  <= 1'b0;
            near_of_o <= 1'b0;
        end else if (en_i) begin
            result_o  <= res_d;
            fflags_o  <= flags_d;
            far_uf_o  <= spec_i.sel_far & uf;
            near_of_o <= ~spec_i.sel_far & of;
        end
    end

    // overflow always leaves an infinity on the output
    of_packs_inf_a: assert property (@(posedge clk) disable iff (!rst_n)
        fflags_o[IDX_OF] |-> (result_o.exp == EXP_MAX && result_o.frac == '0))
        else $error("OF set without an infinity result");

endmodule

// ==== tc_add.sv ====
`timescale 1ns/1ns

module tc_add
    import tc_fmt_pkg::*, tc_flag_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en_i,         // global stall, low freezes all stages
    input  in_operand_t a_i,
    input  in_operand_t b_i,
    output out_result_t result_o,
    output fflags_t     fflags_o,
    output logic        far_uf_o,
    output logic        near_of_o
);

    // stage 1 to stage 2
    logic [ALIGN_W-1:0] s1_sum;
    logic [EXP_W-1:0]   s1_exp_large;
    in_operand_t        s1_a;
    in_operand_t        s1_b;
    logic               s1_bypass_a0;
    logic               s1_bypass_b0;
    special_t           s1_spec;

    // stage 2 to stage 3
    pre_round_t         s2_sig;
    special_t           s2_spec;

    fp_align_add u_align_add (
        .clk         (clk),
        .rst_n       (rst_n),
        .en_i        (en_i),
        .a_i         (a_i),
        .b_i         (b_i),
        .sum_o       (s1_sum),
        .exp_large_o (s1_exp_large),
        .a_o         (s1_a),
        .b_o         (s1_b),
        .bypass_a0_o (s1_bypass_a0),
        .bypass_b0_o (s1_bypass_b0),
        .spec_o      (s1_spec)
    );

    fp_normalize u_normalize (
        .clk         (clk),
        .rst_n       (rst_n),
        .en_i        (en_i),
        .sum_i       (s1_sum),
        .exp_large_i (s1_exp_large),
        .a_i         (s1_a),
        .b_i         (s1_b),
        .bypass_a0_i (s1_bypass_a0),
        .bypass_b0_i (s1_bypass_b0),
        .spec_i      (s1_spec),
        .sig_o       (s2_sig),
        .spec_o      (s2_spec)
    );

    fp_round_pack u_round_pack (
        .clk       (clk),
        .rst_n     (rst_n),
        .en_i      (en_i),
        .sig_i     (s2_sig),
        .spec_i    (s2_spec),
        .result_o  (result_o),
        .fflags_o  (fflags_o),
        .far_uf_o  (far_uf_o),
        .near_of_o (near_of_o)
    );

endmodule

// ==== tb_tc_add.sv ====
`timescale 1ns/1ns

module tb_tc_add
    import tc_fmt_pkg::*, tc_flag_pkg::*;
;

    localparam int NUM_VEC    = 31;
    localparam int WORDS      = 6;     // a, b, result, fflags, far_uf, near_of
    localparam int LATENCY    = 3;
    localparam int BURST_VEC  = 10;    // leading vectors go back to back
    localparam int MAX_CYCLES = 2000;

    logic        clk;
    logic        rst_n;
    logic        en;
    in_operand_t a;
    in_operand_t b;
    out_result_t result;
    fflags_t     fflags;
    logic        far_uf;
    logic        near_of;

    logic [15:0] stim_mem [0:NUM_VEC*WORDS-1];
    int          pipe [0:LATENCY-1];   // vector index per stage, -1 is a bubble
    int          next_vec;
    int          checked;
    int          cycles;
    logic        last_en;
    out_result_t held_result;
    fflags_t     held_fflags;
    logic        held_far_uf;
    logic        held_near_of;
    logic [31:0] rnd;

    tc_add dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en_i      (en),
        .a_i       (a),
        .b_i       (b),
        .result_o  (result),
        .fflags_o  (fflags),
        .far_uf_o  (far_uf),
        .near_of_o (near_of)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp) begin
            $display("mismatch %s got %0h expected %0h", name, got, exp);
            $display("test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    // expected values come straight from the stim columns
    task automatic compare_outputs(input int idx);
        check_value("result_o", {6'd0, result}, stim_mem[idx*WORDS+2]);
        check_value("fflags_o", {11'd0, fflags}, stim_mem[idx*WORDS+3]);
        check_value("far_uf_o", {15'd0, far_uf}, stim_mem[idx*WORDS+4]);
        check_value("near_of_o", {15'd0, near_of}, stim_mem[idx*WORDS+5]);
    endtask

    task automatic compare_held();
        check_value("result_o", {6'd0, result}, {6'd0, held_result});
        check_value("fflags_o", {11'd0, fflags}, {11'd0, held_fflags});
        check_value("far_uf_o", {15'd0, far_uf}, {15'd0, held_far_uf});
        check_value("near_of_o", {15'd0, near_of}, {15'd0, held_near_of});
    endtask

    function automatic logic pipe_empty();
        logic empty;
        empty = 1'b1;
        for (int i = 0; i < LATENCY; i++) begin
            if (pipe[i] >= 0) empty = 1'b0;
        end
        return empty;
    endfunction

    // one enabled edge moves every entry one stage on
    task automatic shift_pipe(input int idx);
        for (int i = LATENCY-1; i > 0; i--) begin
            pipe[i] = pipe[i-1];
        end
        pipe[0] = idx;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        en           = 1'b0;
        a            = '0;
        b            = '0;
        held_result  = '0;
        held_fflags  = '0;
        held_far_uf  = 1'b0;
        held_near_of = 1'b0;
        next_vec     = 0;
        checked      = 0;
        cycles       = 0;
        last_en      = 1'b0;
        rnd          = $urandom(32'hee8b);
        for (int i = 0; i < LATENCY; i++) begin
            pipe[i] = -1;
        end

        for (int i = 0; i < NUM_VEC*WORDS; i++) begin
            stim_mem[i] = 16'h8000 | 16'(i);  // bit 15 lies above every real column
        end
        $readmemh("tc_add_stim.txt", stim_mem);
        if (stim_mem[NUM_VEC*WORDS-1][15]) begin
            $display("stim file is missing or holds too few vectors");
            $display("test failed");
            $fatal(1, "no stimulus");
        end

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("result_o", {6'd0, result}, 16'h0);
        check_value("fflags_o", {11'd0, fflags}, 16'h0);
        check_value("far_uf_o", {15'd0, far_uf}, 16'h0);
        check_value("near_of_o", {15'd0, near_of}, 16'h0);

        while ((next_vec < NUM_VEC || !pipe_empty()) && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (pipe[LATENCY-1] >= 0) begin
                compare_outputs(pipe[LATENCY-1]);
                if (last_en) checked++;    // count each vector once
            end
            if (!last_en) compare_held();
            held_result  = result;
            held_fflags  = fflags;
            held_far_uf  = far_uf;
            held_near_of = near_of;

            en = !((next_vec >= BURST_VEC) && ($urandom % 4 == 0));
            if (!en) begin
                rnd = $urandom;
                a   = rnd[13:0];           // junk while stalled
                b   = rnd[29:16];
            end else if (next_vec < NUM_VEC) begin
                a = stim_mem[next_vec*WORDS][13:0];
                b = stim_mem[next_vec*WORDS+1][13:0];
                shift_pipe(next_vec);
                next_vec++;
            end else begin
                a = '0;
                b = '0;
                shift_pipe(-1);
            end
            last_en = en;
        end

        if (next_vec < NUM_VEC || !pipe_empty()) begin
            $display("timed out after %0d cycles with vectors still in flight", cycles);
            $display("test failed");
            $fatal(1, "pipeline did not drain");
        end else if (checked != NUM_VEC) begin
            $display("only %0d of %0d vectors reached the output", checked, NUM_VEC);
            $display("test failed");
            $fatal(1, "vectors lost");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== tc_add_stim.txt ====
// each line holds a b result fflags far_uf near_of in hex
// operands are 1-5-8 and results are 1-5-4 with fflags as NV OF UF DZ NX
0f00 0f00 100 00 0 0
0f80 0f40 106 00 0 0
0f0c 0f00 100 01 0 0
0f00 0f30 102 01 0 0
0f00 0f10 100 01 0 0
0f00 0f11 101 01 0 0
0f00 0c00 0f2 00 0 0
1400 0fff 141 01 0 0
0f80 2f00 0e0 00 0 0
0f00 2f80 2e0 00 0 0
2f40 0e80 2e0 00 0 0
0f00 2501 0f0 01 0 0
1f00 0f00 1f0 00 0 0
0f00 3f00 3f0 00 0 0
1f00 3f00 1f8 10 0 0
1f40 0f00 1f8 00 0 0
0f00 3f80 1f8 00 0 0
1f01 3f00 1f8 00 0 0
0000 0f35 0f3 01 0 0
2f80 0000 2f8 00 0 0
0f35 2f35 000 00 0 0
2f80 0f80 000 00 0 0
0000 2000 000 00 0 0
1ef8 0000 1f0 09 0 0
1ef0 1e00 1f0 09 0 1
1e00 1df2 1f0 09 0 1
3ef8 3400 3f0 09 0 0
0000 0005 000 05 0 0
0101 2100 000 05 0 0
0180 2100 008 00 0 0
0188 2100 008 01 0 0

// ==== list.f ====
tc_fmt_pkg.sv
tc_flag_pkg.sv
fp_align_add.sv
fp_normalize.sv
fp_round_pack.sv
tc_add.sv
tb_tc_add.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_tc_add -f list.f -o sim_tc_add || exit 1
out=$(./obj_dir/sim_tc_add 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "test passed" && exit 0 || exit 1
